//--- class_router.f
src/router_pkg.sv
src/sync_fifo.sv
src/class_demux.sv
src/class_arbiter.sv
src/class_router.sv
verif/tb_class_router.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the class router testbench with Verilator.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

TOP=tb_class_router
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -f class_router.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
  echo "Result: testbench passed"
  exit 0
else
  echo "Result: testbench failed, see $LOG"
  exit 1
fi

//--- verif/tb_class_router.sv
`timescale 1ns/1ps

module tb_class_router;

  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_DLY    = 2;   // Input skew after rising edge
  localparam int RESET_CYCLES = 4;
  localparam int NUM_RANDOM   = 40;  // Mixed traffic with up to 3 idle cycles per word
  localparam int NUM_PRIO     = 16;  // Back to back words for destination 1
  localparam int NUM_BLOCK    = 10;  // Pushes output 0 past almost full
  localparam int NUM_FLOW     = 6;   // Class 1 words that pass the blocked class
  localparam int NUM_BURST    = router_pkg::FIFO_DEPTH + 3;
  localparam int IDLE_CYCLES  = 20;  // Window for duplicate deliveries
  localparam int STIM_CYCLES  = RESET_CYCLES + NUM_RANDOM * 4 + NUM_PRIO + NUM_BLOCK
                              + NUM_FLOW + NUM_BURST + 2 + IDLE_CYCLES;
  localparam int CYCLE_LIMIT  = 4 * STIM_CYCLES + 200;

  // Only empty and almost empty raised
  localparam router_pkg::fifo_status_t IDLE_STATUS = 4'b1100;

  // One accepted word with its arrival order
  typedef struct packed {
    logic [31:0]              seq;
    router_pkg::router_word_t word;
  } ref_entry_t;

  logic                                  clk;
  logic                                  reset;
  logic                                  in_push;
  router_pkg::router_word_t              in_word;
  logic                                  pop_out0;
  logic                                  pop_out1;
  router_pkg::router_word_t              out_word0;
  router_pkg::router_word_t              out_word1;
  router_pkg::fifo_status_t              out_status0;
  router_pkg::fifo_status_t              out_status1;
  logic [router_pkg::DROP_W-1:0]         drop_count;

  logic        push_ok;     // Model expects the current push to be kept
  logic        prio_check;  // Priority rule applies
  logic        bp_phase;    // Output 0 held and must never fill
  logic [7:0]  exp_drops;
  logic [7:0]  drops_before;
  logic [31:0] push_seq;
  logic [31:0] r;
  int          errors;
  int          accepted;
  int          delivered;
  int          cycle_count;
  int          seed;
  int          i;

  ref_entry_t ref_q [2][2][$];  // Indexed by class and destination

  class_router u_dut (
    .clk         (clk),
    .reset       (reset),
    .in_push     (in_push),
    .in_word     (in_word),
    .pop_out0    (pop_out0),
    .pop_out1    (pop_out1),
    .out_word0   (out_word0),
    .out_word1   (out_word1),
    .out_status0 (out_status0),
    .out_status1 (out_status1),
    .drop_count  (drop_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Hard stop for a stuck run
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, router never reached the expected state",
               cycle_count);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic flag_mismatch(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
    errors = errors + 1;
    $display("[FAIL] %0t: %s expected %0h, actual %0h", $time, name, exp_val, act_val);
  endtask

  task automatic report_problem(input string msg);
    errors = errors + 1;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic send_word(input logic cls, input logic dest, input logic [7:0] payload,
                           input logic accept);
    in_word.cls     = cls;
    in_word.dest    = dest;
    in_word.payload = payload;
    in_push         = 1'b1;
    push_ok         = accept;  // Model side of the drop rule
    step_cycle();
    in_push = 1'b0;
    push_ok = 1'b0;
  endtask

  function automatic int pending_words();
    return ref_q[0][0].size() + ref_q[0][1].size() + ref_q[1][0].size() + ref_q[1][1].size();
  endfunction

  task automatic wait_drained();
    while (pending_words() != 0 || !out_status0.empty || !out_status1.empty) begin
      step_cycle();
    end
  endtask

  task automatic record_push(input router_pkg::router_word_t w);
    ref_entry_t entry;
    entry.seq  = push_seq;
    entry.word = w;
    ref_q[w.cls][w.dest].push_back(entry);
    accepted = accepted + 1;
  endtask

  // Compare a popped output word with the oldest matching reference entry
  task automatic check_output(input int d, input logic pop, input router_pkg::fifo_status_t st,
                              input router_pkg::router_word_t w);
    ref_entry_t exp_e;
    int         c;
    if (pop && !st.empty) begin
      c = int'(w.cls);
      assert (ref_q[c][d].size() != 0)
        else report_problem($sformatf("output %0d delivered word %0h with nothing pending",
                                      d, w));
      if (ref_q[c][d].size() != 0) begin
        exp_e = ref_q[c][d].pop_front();
        delivered = delivered + 1;
        assert (w == exp_e.word)
          else flag_mismatch($sformatf("out_word%0d", d), {22'd0, exp_e.word}, {22'd0, w});
        if (prio_check && w.cls) begin
          assert (ref_q[0][d].size() == 0 || ref_q[0][d][0].seq > exp_e.seq)
            else report_problem("class 1 word passed an older pending class 0 word");
        end
      end
    end
  endtask

  // Monitor at the falling edge where everything is settled
  always @(negedge clk) begin
    if (reset) begin
      assert (drop_count == exp_drops)
        else flag_mismatch("drop_count", {24'd0, exp_drops}, {24'd0, drop_count});
      if (bp_phase) begin
        assert (!out_status0.full)
          else report_problem("output FIFO 0 reached full while it was held");
      end
      if (in_push) begin
        if (push_ok) begin
          record_push(in_word);
        end else if (exp_drops != 8'hff) begin
          exp_drops = exp_drops + 8'd1;  // Saturates at all ones
        end
        push_seq = push_seq + 32'd1;
      end
      check_output(0, pop_out0, out_status0, out_word0);
      check_output(1, pop_out1, out_status1, out_word1);
    end
  end

  initial begin
    reset       = 1'b0;
    in_push     = 1'b0;
    in_word     = '0;
    pop_out0    = 1'b0;
    pop_out1    = 1'b0;
    push_ok     = 1'b0;
    prio_check  = 1'b0;
    bp_phase    = 1'b0;
    exp_drops   = 8'd0;
    push_seq    = 32'd0;
    errors      = 0;
    accepted    = 0;
    delivered   = 0;
    cycle_count = 0;
    seed        = 32'hc67229cc;

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    reset = 1'b1;
    @(negedge clk);
    assert (out_status0 == IDLE_STATUS)
      else flag_mismatch("out_status0", {28'd0, IDLE_STATUS}, {28'd0, out_status0});
    assert (out_status1 == IDLE_STATUS)
      else flag_mismatch("out_status1", {28'd0, IDLE_STATUS}, {28'd0, out_status1});
    assert (drop_count == 8'd0)
      else flag_mismatch("drop_count", 32'd0, {24'd0, drop_count});
    step_cycle();

    // Mixed traffic with both outputs drained every cycle
    pop_out0 = 1'b1;
    pop_out1 = 1'b1;
    for (i = 0; i < NUM_RANDOM; i++) begin
      r = $random(seed);
      send_word(r[8], r[9], r[7:0], 1'b1);
      repeat (int'(r[11:10])) step_cycle();
    end
    wait_drained();

    // Both classes racing for destination 1
    prio_check = 1'b1;
    for (i = 0; i < NUM_PRIO; i++) begin
      r = $random(seed);
      send_word(r[0], 1'b1, 8'(i), 1'b1);
    end
    wait_drained();
    prio_check = 1'b0;

    // Output 0 held so class 0 stalls behind it
    pop_out0 = 1'b0;
    bp_phase = 1'b1;
    for (i = 0; i < NUM_BLOCK; i++) begin
      send_word(1'b0, 1'b0, 8'(8'h40 + i), 1'b1);
    end
    while (!out_status0.almost_full) step_cycle();
    for (i = 0; i < NUM_FLOW; i++) begin
      send_word(1'b1, 1'b1, 8'(8'h60 + i), 1'b1);
    end
    while (ref_q[1][1].size() != 0) step_cycle();  // Destination 1 still moves
    // Held output keeps showing the first blocked word
    assert (out_word0 == {router_pkg::CLASS_0, router_pkg::DEST_0, 8'h40})
      else flag_mismatch("out_word0",
                         {22'd0, router_pkg::CLASS_0, router_pkg::DEST_0, 8'h40},
                         {22'd0, out_word0});

    // Class 1 burst toward the blocked output where only FIFO_DEPTH fit
    drops_before = exp_drops;
    for (i = 0; i < NUM_BURST; i++) begin
      send_word(1'b1, 1'b0, 8'(8'h80 + i), i < router_pkg::FIFO_DEPTH);
    end
    assert (drop_count == drops_before + 8'(NUM_BURST - router_pkg::FIFO_DEPTH))
      else flag_mismatch("drop_count", {24'd0, drops_before + 8'(NUM_BURST -
                         router_pkg::FIFO_DEPTH)}, {24'd0, drop_count});
    pop_out0 = 1'b1;
    wait_drained();
    bp_phase = 1'b0;

    // Lone words that must each come out exactly once
    send_word(1'b0, 1'b1, 8'hc1, 1'b1);
    wait_drained();
    send_word(1'b1, 1'b0, 8'hc2, 1'b1);
    wait_drained();
    repeat (IDLE_CYCLES) step_cycle();

    // Idle router shows empty outputs with no stray flag
    assert (out_status0 == IDLE_STATUS)
      else flag_mismatch("out_status0", {28'd0, IDLE_STATUS}, {28'd0, out_status0});
    assert (out_status1 == IDLE_STATUS)
      else flag_mismatch("out_status1", {28'd0, IDLE_STATUS}, {28'd0, out_status1});

    $display("Errors: %0d, accepted: %0d, delivered: %0d, dropped: %0d, cycles: %0d",
             errors, accepted, delivered, exp_drops, cycle_count);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- src/class_router.sv
`timescale 1ns/1ps

module class_router (
  input  logic                          clk,
  input  logic                          reset,        // Sync, active low
  input  logic                          in_push,      // Strobe with in_word
  input  router_pkg::router_word_t      in_word,
  input  logic                          pop_out0,     // Drain strobe, output 0
  input  logic                          pop_out1,     // Drain strobe, output 1
  output router_pkg::router_word_t      out_word0,    // Head of output FIFO 0
  output router_pkg::router_word_t      out_word1,    // Head of output FIFO 1
  output router_pkg::fifo_status_t      out_status0,
  output router_pkg::fifo_status_t      out_status1,
  output logic [router_pkg::DROP_W-1:0] drop_count
);

  // Decode to class FIFOs
  logic                     push_c0;
  logic                     push_c1;
  router_pkg::router_word_t word_c;

  // Class FIFOs back to arbiter and demux
  router_pkg::router_word_t head_c0;
  router_pkg::router_word_t head_c1;
  router_pkg::fifo_status_t status_c0;
  router_pkg::fifo_status_t status_c1;

  // Arbiter pops and output pushes
  logic                     pop_c0;
  logic                     pop_c1;
  logic                     push_o0;
  logic                     push_o1;
  router_pkg::router_word_t word_o;

  // Decode stage
  class_demux u_class_demux (
    .clk        (clk),
    .reset      (reset),
    .in_push    (in_push),
    .in_word    (in_word),
    .status_c0  (status_c0),
    .status_c1  (status_c1),
    .push_c0    (push_c0),
    .push_c1    (push_c1),
    .word_c     (word_c),
    .drop_count (drop_count)
  );

  // Class 0 queue, priority class
  sync_fifo u_fifo_c0 (
    .clk       (clk),
    .reset     (reset),
    .push      (push_c0),
    .push_word (word_c),
    .pop       (pop_c0),
    .head_word (head_c0),
    .status    (status_c0)
  );

  // Class 1 queue
  sync_fifo u_fifo_c1 (
    .clk       (clk),
    .reset     (reset),
    .push      (push_c1),
    .push_word (word_c),
    .pop       (pop_c1),
    .head_word (head_c1),
    .status    (status_c1)
  );

  // Execute stage, priority pops and destination routing
  class_arbiter u_class_arbiter (
    .clk       (clk),
    .reset     (reset),
    .head_c0   (head_c0),
    .head_c1   (head_c1),
    .status_c0 (status_c0),
    .status_c1 (status_c1),
    .status_o0 (out_status0),
    .status_o1 (out_status1),
    .pop_c0    (pop_c0),
    .pop_c1    (pop_c1),
    .push_o0   (push_o0),
    .push_o1   (push_o1),
    .word_o    (word_o)
  );

  // Result stage, drained from outside
  sync_fifo u_fifo_o0 (
    .clk       (clk),
    .reset     (reset),
    .push      (push_o0),
    .push_word (word_o),
    .pop       (pop_out0),
    .head_word (out_word0),
    .status    (out_status0)
  );

  sync_fifo u_fifo_o1 (
    .clk       (clk),
    .reset     (reset),
    .push      (push_o1),
    .push_word (word_o),
    .pop       (pop_out1),
    .head_word (out_word1),
    .status    (out_status1)
  );

endmodule

//--- src/class_arbiter.sv
`timescale 1ns/1ps

module class_arbiter (
  input  logic                     clk,
  input  logic                     reset,      // Sync, active low
  input  router_pkg::router_word_t head_c0,    // Class 0 head, shown ahead
  input  router_pkg::router_word_t head_c1,    // Class 1 head, shown ahead
  input  router_pkg::fifo_status_t status_c0,
  input  router_pkg::fifo_status_t status_c1,
  input  router_pkg::fifo_status_t status_o0,  // Output FIFO 0 level
  input  router_pkg::fifo_status_t status_o1,  // Output FIFO 1 level
  output logic                     pop_c0,     // Registered
  output logic                     pop_c1,     // Registered
  output logic                     push_o0,
  output logic                     push_o1,
  output router_pkg::router_word_t word_o
);

  // Output level seen by each class head
  router_pkg::fifo_status_t dest_status_c0;
  router_pkg::fifo_status_t dest_status_c1;

  logic blocked_c0;  // Head word targets an almost full output
  logic blocked_c1;
  logic paced_c0;    // Almost empty and popped this cycle, skip one
  logic paced_c1;
  logic cand_c0;     // Class 0 may pop next cycle
  logic cand_c1;     // Class 1 may pop next cycle

  logic                     word_valid;  // A word leaves a class FIFO this cycle
  router_pkg::router_word_t sel_word;    // Word picked by priority

  // Destination lookup per head word
  assign dest_status_c0 = (head_c0.dest == router_pkg::DEST_1) ? status_o1 : status_o0;
  assign dest_status_c1 = (head_c1.dest == router_pkg::DEST_1) ? status_o1 : status_o0;

  assign blocked_c0 = dest_status_c0.almost_full;
  assign blocked_c1 = dest_status_c1.almost_full;

  // Pop lands one cycle late, so a lone word must not be popped twice
  assign paced_c0 = status_c0.almost_empty && pop_c0;
  assign paced_c1 = status_c1.almost_empty && pop_c1;

  assign cand_c0 = !status_c0.empty && !blocked_c0 && !paced_c0;
  assign cand_c1 = !status_c1.empty && !blocked_c1 && !paced_c1;

  // Registered pops, class 0 wins
  always_ff @(posedge clk) begin
    if (!reset) begin
      pop_c0 <= 1'b0;
      pop_c1 <= 1'b0;
    end else begin
      if (cand_c0) begin
        pop_c0 <= 1'b1;
        pop_c1 <= 1'b0;       // Class 1 waits
      end else begin
        pop_c0 <= 1'b0;
        pop_c1 <= cand_c1;
      end
    end
  end

  // Pick the word that leaves with the pop
  always_comb begin
    word_valid = 1'b0;
    sel_word   = '0;
    if (pop_c0 && !status_c0.empty) begin
      word_valid = 1'b1;
      sel_word   = head_c0;
    end else if (pop_c1 && !status_c1.empty) begin
      word_valid = 1'b1;
      sel_word   = head_c1;
    end
  end

  // Destination bit steers the output push
  always_comb begin
    push_o0 = 1'b0;
    push_o1 = 1'b0;
    if (word_valid) begin
      if (sel_word.dest == router_pkg::DEST_1) begin
        push_o1 = 1'b1;
      end else begin
        push_o0 = 1'b1;
      end
    end
  end

  // Same bus feeds both output FIFOs
  assign word_o = sel_word;

endmodule

//--- src/class_demux.sv
`timescale 1ns/1ps

module class_demux (
  input  logic                              clk,
  input  logic                              reset,      // Sync active low
  input  logic                              in_push,    // Strobe with in_word
  input  router_pkg::router_word_t          in_word,
  input  router_pkg::fifo_status_t          status_c0,  // Class 0 FIFO level
  input  router_pkg::fifo_status_t          status_c1,  // Class 1 FIFO level
  output logic                              push_c0,
  output logic                              push_c1,
  output router_pkg::router_word_t          word_c,     // Shared by both class FIFOs
  output logic [router_pkg::DROP_W-1:0]     drop_count  // Saturating
);

  logic target_full;  // Selected class FIFO has no room
  logic drop;         // Word arrives but is thrown away

  // Class bit picks which FIFO level matters
  assign target_full = (in_word.cls == router_pkg::CLASS_1) ? status_c1.full
                                                             : status_c0.full;

  assign drop = in_push && target_full;

  // Only the matching class sees the strobe
  always_comb begin
    push_c0 = 1'b0;
    push_c1 = 1'b0;
    if (in_push && !target_full) begin
      if (in_word.cls == router_pkg::CLASS_1) begin
        push_c1 = 1'b1;
      end else begin
        push_c0 = 1'b1;  // Class 0 push
      end
    end
  end

  // Word goes to both FIFOs and the strobe picks the keeper
  assign word_c = in_word;

  // Drop counter stops at all ones
  always_ff @(posedge clk) begin
    if (!reset) begin
      drop_count <= '0;
    end else if (drop && (drop_count != '1)) begin
      drop_count <= drop_count + 1'b1;
    end
  end

endmodule

//--- src/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo (
  input  logic                     clk,
  input  logic                     reset,      // Sync, active low
  input  logic                     push,
  input  router_pkg::router_word_t push_word,
  input  logic                     pop,
  output router_pkg::router_word_t head_word,  // Shown ahead of the pop
  output router_pkg::fifo_status_t status
);

  // Storage, no reset on payload
  router_pkg::router_word_t mem [router_pkg::FIFO_DEPTH];

  logic [router_pkg::PTR_W-1:0] wr_ptr;  // Next slot to write
  logic [router_pkg::PTR_W-1:0] rd_ptr;  // Current head slot
  logic [router_pkg::PTR_W:0]   count;   // Occupancy, one bit wider than pointers

  logic do_push;  // Qualified push
  logic do_pop;   // Qualified pop

  // Push when full and pop when empty are dropped here
  assign do_push = push && !status.full;
  assign do_pop  = pop && !status.empty;

  // Write side
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_word;
    end
  end

  // Pointers wrap naturally at depth 8
  always_ff @(posedge clk) begin
    if (!reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy tracking
  always_ff @(posedge clk) begin
    if (!reset) begin
      count <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;  // Push only
        2'b01:   count <= count - 1'b1;  // Pop only
        default: count <= count;         // Both or neither, level holds
      endcase
    end
  end

  // Head word straight from storage
  assign head_word = mem[rd_ptr];

  // Level flags against package thresholds
  assign status.empty =
    (count == '0);
  assign status.almost_empty =
    (count <= (router_pkg::PTR_W + 1)'(router_pkg::ALMOST_EMPTY_LVL));
  assign status.full =
    (count == (router_pkg::PTR_W + 1)'(router_pkg::FIFO_DEPTH));
  assign status.almost_full =
    (count >= (router_pkg::PTR_W + 1)'(router_pkg::ALMOST_FULL_LVL));

endmodule

//--- src/router_pkg.sv
package router_pkg;

  // Word and payload widths
  localparam int WORD_W    = 10;
  localparam int PAYLOAD_W = 8;

  // Every FIFO in the router has the same depth
  localparam int FIFO_DEPTH = 8;
  localparam int PTR_W      = 3;  // log2 of FIFO_DEPTH

  // Occupancy thresholds for the soft flags
  localparam int ALMOST_FULL_LVL  = 6;  // Two entries of slack for a pop in flight
  localparam int ALMOST_EMPTY_LVL = 1;  // Single word left

  // Router word as it travels through every stage
  typedef struct packed {
    logic                 cls;      // Class select, 0 has priority
    logic                 dest;     // Output FIFO select
    logic [PAYLOAD_W-1:0] payload;
  } router_word_t;

  // FIFO level flags, all derived from occupancy
  typedef struct packed {
    logic empty;
    logic almost_empty;
    logic full;
    logic almost_full;
  } fifo_status_t;

  // Word struct must fill the bus exactly
  localparam int WORD_BITS = $bits(router_word_t);

  // Status struct size, for port sizing checks
  localparam int STATUS_BITS = $bits(fifo_status_t);

  // Class and destination encodings
  localparam logic CLASS_0 = 1'b0;
  localparam logic CLASS_1 = 1'b1;
  localparam logic DEST_0  = 1'b0;
  localparam logic DEST_1  = 1'b1;

  // Width of the saturating drop counter
  localparam int DROP_W = 8;

endpackage
